// ==== vlog.f ====
+incdir+tests
src/fp_pkg.sv
src/isog_pkg.sv
src/isog_ifs.sv
src/fp_mul.sv
src/kernel_multiples.sv
src/eval_accum.sv
src/curve_accum.sv
src/isog_finish.sv
src/xisog_top.sv
tests/tb_xisog.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_xisog -f vlog.f -o sim_xisog
./obj_dir/sim_xisog | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

// ==== tests/xisog_model.svh ====
`ifndef XISOG_MODEL_SVH
`define XISOG_MODEL_SVH
`default_nettype none

// reference field arithmetic on wide integers, reduced after every step
function automatic fp_pkg::fp_t mod_add(input fp_pkg::fp_t a, input fp_pkg::fp_t b,
                                        input fp_pkg::fp_t p);
    longint unsigned s;
    s = (longint'(a) + longint'(b)) % longint'(p);
    return fp_pkg::fp_t'(s);
endfunction

function automatic fp_pkg::fp_t mod_sub(input fp_pkg::fp_t a, input fp_pkg::fp_t b,
                                        input fp_pkg::fp_t p);
    longint unsigned d;
    d = (longint'(a) + longint'(p) - longint'(b)) % longint'(p);
    return fp_pkg::fp_t'(d);
endfunction

function automatic fp_pkg::fp_t mod_mul(input fp_pkg::fp_t a, input fp_pkg::fp_t b,
                                        input fp_pkg::fp_t p);
    longint unsigned m;
    m = (longint'(a) * longint'(b)) % longint'(p);
    return fp_pkg::fp_t'(m);
endfunction

// walks M_1 .. M_(l-1)/2 and applies both accumulations and the finishing step
task automatic isogeny_expected(
    input fp_pkg::fp_t px,
    input fp_pkg::fp_t pz,
    input fp_pkg::fp_t kx,
    input fp_pkg::fp_t kz,
    input fp_pkg::fp_t a24,
    input isog_pkg::deg_t l,
    input fp_pkg::fp_t p,
    output fp_pkg::fp_t px_new,
    output fp_pkg::fp_t pz_new,
    output fp_pkg::fp_t prod_x,
    output fp_pkg::fp_t prod_z
);
    fp_pkg::fp_t x, z, xp, zp, xn, zn;
    fp_pkg::fp_t t0, t1, c, u, v, a, b;
    fp_pkg::fp_t qx, qz, cx, cz;
    int i;
    x = kx;
    z = kz;
    xp = kx;
    zp = kz;
    xn = kx;
    zn = kz;
    qx = 16'd1;
    qz = 16'd1;
    cx = 16'd1;
    cz = 16'd1;
    for (i = 1; i <= int'(l) / 2; i++) begin
        if (i == 2) begin
            // x-only doubling of K
            t0 = mod_mul(mod_add(x, z, p), mod_add(x, z, p), p);
            t1 = mod_mul(mod_sub(x, z, p), mod_sub(x, z, p), p);
            c = mod_sub(t0, t1, p);
            xn = mod_mul(t0, t1, p);
            zn = mod_mul(c, mod_add(t1, mod_mul(a24, c, p), p), p);
        end else if (i > 2) begin
            // M_i = M_(i-1) + K with difference M_(i-2)
            u = mod_mul(mod_sub(x, z, p), mod_add(kx, kz, p), p);
            v = mod_mul(mod_add(x, z, p), mod_sub(kx, kz, p), p);
            xn = mod_mul(zp, mod_mul(mod_add(u, v, p), mod_add(u, v, p), p), p);
            zn = mod_mul(xp, mod_mul(mod_sub(u, v, p), mod_sub(u, v, p), p), p);
        end
        if (i > 1) begin
            xp = x;
            zp = z;
            x = xn;
            z = zn;
        end
        a = mod_mul(mod_sub(px, pz, p), mod_add(x, z, p), p);
        b = mod_mul(mod_add(px, pz, p), mod_sub(x, z, p), p);
        qx = mod_mul(qx, mod_add(a, b, p), p);
        qz = mod_mul(qz, mod_sub(a, b, p), p);
        cx = mod_mul(cx, mod_sub(x, z, p), p);
        cz = mod_mul(cz, mod_add(x, z, p), p);
    end
    px_new = mod_mul(px, mod_mul(qx, qx, p), p);
    pz_new = mod_mul(pz, mod_mul(qz, qz, p), p);
    prod_x = cx;
    prod_z = cz;
endtask

`default_nettype wire
`endif

// ==== tests/tb_xisog.sv ====
`timescale 1ns/1ns
`include "xisog_model.svh"
`default_nettype none

module tb_xisog;

    localparam fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P;
    localparam isog_pkg::deg_t MAX_L = isog_pkg::DEFAULT_MAX_L;
    localparam int NUM_CASES = 26;
    localparam int SEED = 75283;
    localparam int TIMEOUT_CYCLES = NUM_CASES * int'(MAX_L) * 8 * (fp_pkg::FP_W + 4);

    typedef struct packed {
        fp_pkg::fp_t px;
        fp_pkg::fp_t pz;
        fp_pkg::fp_t kx;
        fp_pkg::fp_t kz;
        fp_pkg::fp_t a24;
        isog_pkg::deg_t l;
        logic rst_mid;
        fp_pkg::fp_t exp_px;
        fp_pkg::fp_t exp_pz;
        fp_pkg::fp_t exp_cx;
        fp_pkg::fp_t exp_cz;
    } case_t;

    logic clk;
    logic rst;
    logic req;
    fp_pkg::fp_t px;
    fp_pkg::fp_t pz;
    fp_pkg::fp_t kx;
    fp_pkg::fp_t kz;
    fp_pkg::fp_t a24;
    isog_pkg::deg_t l;
    logic ack;
    fp_pkg::fp_t px_new;
    fp_pkg::fp_t pz_new;
    fp_pkg::fp_t prod_x;
    fp_pkg::fp_t prod_z;

    case_t cases [NUM_CASES];
    string case_name [NUM_CASES];
    int checks;
    int errors;
    int cycles;

    xisog_top #(.PRIME(PRIME), .MAX_L(MAX_L)) DUT (
        .clk(clk), .rst(rst), .req(req), .px(px), .pz(pz),
        .kx(kx), .kz(kz), .a24(a24), .l(l), .ack(ack),
        .px_new(px_new), .pz_new(pz_new), .prod_x(prod_x), .prod_z(prod_z)
    );

    always #10 clk = ~clk;

    function automatic fp_pkg::fp_t rand_elem();
        return fp_pkg::fp_t'($urandom % 32'(PRIME));
    endfunction

    // odd degree from 3 up to MAX_L
    function automatic isog_pkg::deg_t rand_degree();
        return isog_pkg::deg_t'(3 + 2 * ($urandom % ((int'(MAX_L) - 1) / 2)));
    endfunction

    task automatic set_case(input int idx, input string name,
                            input fp_pkg::fp_t cpx, input fp_pkg::fp_t cpz,
                            input fp_pkg::fp_t ckx, input fp_pkg::fp_t ckz,
                            input fp_pkg::fp_t ca24, input isog_pkg::deg_t cl,
                            input logic cut);
        case_t c;
        c.px = cpx;
        c.pz = cpz;
        c.kx = ckx;
        c.kz = ckz;
        c.a24 = ca24;
        c.l = cl;
        c.rst_mid = cut;
        isogeny_expected(cpx, cpz, ckx, ckz, ca24, cl, PRIME,
                         c.exp_px, c.exp_pz, c.exp_cx, c.exp_cz);
        cases[idx] = c;
        case_name[idx] = name;
    endtask

    task automatic build_table();
        int i;
        set_case(0, "l3_single", 16'd1234, 16'd1, 16'd4321, 16'd7, 16'd9, 7'd3, 1'b0);
        set_case(1, "l5_fixed", 16'h3a5c, 16'h0101, 16'h7f3e, 16'h0001, 16'h2c61, 7'd5, 1'b0);
        set_case(2, "l7_fixed", 16'h3a5c, 16'h0101, 16'h7f3e, 16'h0001, 16'h2c61, 7'd7, 1'b0);
        set_case(3, "l13_fixed", 16'h3a5c, 16'h0101, 16'h7f3e, 16'h0001, 16'h2c61, 7'd13, 1'b0);
        set_case(4, "l31_fixed", 16'h3a5c, 16'h0101, 16'h7f3e, 16'h0001, 16'h2c61, 7'd31, 1'b0);
        for (i = 5; i < NUM_CASES - 1; i++) begin
            set_case(i, $sformatf("random_%0d", i - 5), rand_elem(), rand_elem(),
                     rand_elem(), rand_elem(), rand_elem(), rand_degree(), 1'b0);
        end
        // this job is cut by resets before it runs in full
        set_case(NUM_CASES - 1, "reset_mid_job", 16'hbeef, 16'h0c0d, 16'h1357, 16'h2468,
                 16'h0042, 7'd13, 1'b1);
    endtask

    task automatic check_value(input string name, input string what,
                               input fp_pkg::fp_t exp, input fp_pkg::fp_t got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, got);
        end
    endtask

    task automatic check_outputs(input int idx);
        check_value(case_name[idx], "px_new", cases[idx].exp_px, px_new);
        check_value(case_name[idx], "pz_new", cases[idx].exp_pz, pz_new);
        check_value(case_name[idx], "prod_x", cases[idx].exp_cx, prod_x);
        check_value(case_name[idx], "prod_z", cases[idx].exp_cz, prod_z);
    endtask

    task automatic apply_inputs(input int idx);
        px = cases[idx].px;
        pz = cases[idx].pz;
        kx = cases[idx].kx;
        kz = cases[idx].kz;
        a24 = cases[idx].a24;
        l = cases[idx].l;
    endtask

    // full four-phase exchange, called on a falling edge
    task automatic run_case(input int idx);
        int hold;
        apply_inputs(idx);
        req = 1'b1;
        do @(negedge clk); while (!ack);
        check_outputs(idx);
        hold = 1 + int'($urandom % 5);
        repeat (hold) begin
            @(negedge clk);
            check_value(case_name[idx], "ack held", 16'd1, {15'd0, ack});
            check_outputs(idx);
        end
        req = 1'b0;
        @(negedge clk);
        check_value(case_name[idx], "ack after req low", 16'd0, {15'd0, ack});
        @(negedge clk);
    endtask

    // first cut lands in the arithmetic, second one while the answer is on offer
    task automatic abort_with_reset(input int idx);
        apply_inputs(idx);
        req = 1'b1;
        repeat (200) @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // request still up, so the job starts over
        do @(negedge clk); while (!ack);
        check_outputs(idx);
        rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value(case_name[idx], "ack in reset", 16'd0, {15'd0, ack});
        end
        rst = 1'b0;
        req = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value(case_name[idx], "ack after reset", 16'd0, {15'd0, ack});
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        int i;
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        px = '0;
        pz = '0;
        kx = '0;
        kz = '0;
        a24 = '0;
        l = 7'd3;
        checks = 0;
        errors = 0;
        build_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset", "ack", 16'd0, {15'd0, ack});
        for (i = 0; i < NUM_CASES; i++) begin
            if (cases[i].rst_mid) begin
                abort_with_reset(i);
            end
            run_case(i);
        end
        finish_run();
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("timeout: the design gave no answer within %0d cycles", cycles);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== src/xisog_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module xisog_top #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P,
    parameter isog_pkg::deg_t MAX_L = isog_pkg::DEFAULT_MAX_L
) (
    input wire clk,
    input wire rst,
    input wire req,
    input wire fp_pkg::fp_t px,
    input wire fp_pkg::fp_t pz,
    input wire fp_pkg::fp_t kx,
    input wire fp_pkg::fp_t kz,
    input wire fp_pkg::fp_t a24,
    input wire isog_pkg::deg_t l,
    output logic ack,
    output fp_pkg::fp_t px_new,
    output fp_pkg::fp_t pz_new,
    output fp_pkg::fp_t prod_x,
    output fp_pkg::fp_t prod_z
);

    fp_pkg::fp_t qx;
    fp_pkg::fp_t qz;
    fp_pkg::fp_t prodx;
    fp_pkg::fp_t prodz;
    logic eval_done;
    logic curve_done;

    // every arithmetic block owns its multiplier
    fp_mul_if kern_mul ();
    fp_mul_if eval_mul ();
    fp_mul_if curve_mul ();
    fp_mul_if fin_mul ();
    kernel_point_if pts ();

    fp_mul #(.PRIME(PRIME)) u_kern_mul (.clk(clk), .rst(rst), .mul(kern_mul));
    fp_mul #(.PRIME(PRIME)) u_eval_mul (.clk(clk), .rst(rst), .mul(eval_mul));
    fp_mul #(.PRIME(PRIME)) u_curve_mul (.clk(clk), .rst(rst), .mul(curve_mul));
    fp_mul #(.PRIME(PRIME)) u_fin_mul (.clk(clk), .rst(rst), .mul(fin_mul));

    kernel_multiples #(.PRIME(PRIME), .MAX_L(MAX_L)) u_kernel (
        .clk(clk), .rst(rst), .start(req),
        .kx(kx), .kz(kz), .a24(a24), .l(l),
        .pts(pts), .mul(kern_mul)
    );

    // accumulators rearm while the request is low
    eval_accum #(.PRIME(PRIME)) u_eval (
        .clk(clk), .rst(rst), .clear(!req), .px(px), .pz(pz),
        .pts(pts), .mul(eval_mul), .qx(qx), .qz(qz), .done(eval_done)
    );

    curve_accum #(.PRIME(PRIME)) u_curve (
        .clk(clk), .rst(rst), .clear(!req), .pts(pts), .mul(curve_mul),
        .prodx(prodx), .prodz(prodz), .done(curve_done)
    );

    isog_finish #(.PRIME(PRIME)) u_finish (
        .clk(clk), .rst(rst), .req(req), .px(px), .pz(pz),
        .qx(qx), .qz(qz), .prodx(prodx), .prodz(prodz),
        .eval_done(eval_done), .curve_done(curve_done), .mul(fin_mul),
        .px_new(px_new), .pz_new(pz_new), .prod_x(prod_x), .prod_z(prod_z),
        .ack(ack)
    );

endmodule

`default_nettype wire

// ==== src/isog_finish.sv ====
`timescale 1ns/1ns
`default_nettype none

module isog_finish #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P
) (
    input wire clk,
    input wire rst,
    input wire req,
    input wire fp_pkg::fp_t px,
    input wire fp_pkg::fp_t pz,
    input wire fp_pkg::fp_t qx,
    input wire fp_pkg::fp_t qz,
    input wire fp_pkg::fp_t prodx,
    input wire fp_pkg::fp_t prodz,
    input wire eval_done,
    input wire curve_done,
    fp_mul_if.client mul,
    output fp_pkg::fp_t px_new,
    output fp_pkg::fp_t pz_new,
    output fp_pkg::fp_t prod_x,
    output fp_pkg::fp_t prod_z,
    output logic ack
);

    isog_pkg::fin_state_e state;
    logic [1:0] step;

    // square first, the square is kept in the output register
    always_comb begin
        case (step)
            2'd0: begin
                mul.a = qx;
                mul.b = qx;
            end
            2'd1: begin
                mul.a = px;
                mul.b = px_new;
            end
            2'd2: begin
                mul.a = qz;
                mul.b = qz;
            end
            default: begin
                mul.a = pz;
                mul.b = pz_new;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= isog_pkg::F_IDLE;
            mul.req <= 1'b0;
            ack <= 1'b0;
            step <= '0;
        end else begin
            case (state)
                isog_pkg::F_IDLE: begin
                    if (req && eval_done && curve_done) begin
                        prod_x <= prodx;
                        prod_z <= prodz;
                        step <= '0;
                        state <= isog_pkg::F_CALC;
                    end
                end
                isog_pkg::F_CALC: begin
                    if (mul.req && mul.ack) begin
                        mul.req <= 1'b0;
                        step <= step + 2'd1;
                        if (step[1]) begin
                            pz_new <= mul.prod;
                        end else begin
                            px_new <= mul.prod;
                        end
                        if (step == 2'd3) begin
                            ack <= 1'b1;
                            state <= isog_pkg::F_ACK;
                        end
                    end else if (!mul.req && !mul.ack) begin
                        mul.req <= 1'b1;
                    end
                end
                default: begin
                    if (!req) begin
                        ack <= 1'b0;
                        state <= isog_pkg::F_IDLE;
                    end
                end
            endcase
        end
    end

    // ack follows a dropped request within one cycle
    assert property (@(posedge clk) disable iff (rst) !req && ack |=> !ack);

endmodule

`default_nettype wire

// ==== src/curve_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module curve_accum #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P
) (
    input wire clk,
    input wire rst,
    input wire clear,
    kernel_point_if.curve_sink pts,
    fp_mul_if.client mul,
    output fp_pkg::fp_t prodx,
    output fp_pkg::fp_t prodz,
    output logic done
);

    isog_pkg::acc_state_e state;
    logic step;
    logic last_q;
    fp_pkg::fp_t mx;
    fp_pkg::fp_t mz;

    // prodx takes (Mx-Mz), prodz takes (Mx+Mz)
    assign mul.a = step ? prodz : prodx;
    assign mul.b = step ? fp_pkg::add_mod(mx, mz, PRIME) : fp_pkg::sub_mod(mx, mz, PRIME);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= isog_pkg::A_WAIT;
            pts.ack_curve <= 1'b0;
            mul.req <= 1'b0;
            done <= 1'b0;
            step <= 1'b0;
            prodx <= fp_pkg::fp_t'(1);
            prodz <= fp_pkg::fp_t'(1);
        end else begin
            case (state)
                isog_pkg::A_WAIT: begin
                    if (pts.req) begin
                        mx <= pts.x;
                        mz <= pts.z;
                        last_q <= pts.last;
                        pts.ack_curve <= 1'b1;
                        state <= isog_pkg::A_HOLD;
                    end
                end
                isog_pkg::A_HOLD: begin
                    if (!pts.req) begin
                        pts.ack_curve <= 1'b0;
                        step <= 1'b0;
                        state <= isog_pkg::A_CALC;
                    end
                end
                isog_pkg::A_CALC: begin
                    if (mul.req && mul.ack) begin
                        mul.req <= 1'b0;
                        step <= ~step;
                        if (step) begin
                            prodz <= mul.prod;
                            done <= last_q;
                            state <= last_q ? isog_pkg::A_DONE : isog_pkg::A_WAIT;
                        end else begin
                            prodx <= mul.prod;
                        end
                    end else if (!mul.req && !mul.ack) begin
                        mul.req <= 1'b1;
                    end
                end
                default: begin
                    if (clear) begin
                        done <= 1'b0;
                        prodx <= fp_pkg::fp_t'(1);
                        prodz <= fp_pkg::fp_t'(1);
                        state <= isog_pkg::A_WAIT;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/eval_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module eval_accum #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P
) (
    input wire clk,
    input wire rst,
    input wire clear,
    input wire fp_pkg::fp_t px,
    input wire fp_pkg::fp_t pz,
    kernel_point_if.eval_sink pts,
    fp_mul_if.client mul,
    output fp_pkg::fp_t qx,
    output fp_pkg::fp_t qz,
    output logic done
);

    isog_pkg::acc_state_e state;
    logic [1:0] step;
    logic last_q;
    fp_pkg::fp_t mx;
    fp_pkg::fp_t mz;
    fp_pkg::fp_t ta;
    fp_pkg::fp_t tb;

    // a = (Px-Pz)(Mx+Mz), b = (Px+Pz)(Mx-Mz), then Qx*(a+b) and Qz*(a-b)
    always_comb begin
        case (step)
            2'd0: begin
                mul.a = fp_pkg::sub_mod(px, pz, PRIME);
                mul.b = fp_pkg::add_mod(mx, mz, PRIME);
            end
            2'd1: begin
                mul.a = fp_pkg::add_mod(px, pz, PRIME);
                mul.b = fp_pkg::sub_mod(mx, mz, PRIME);
            end
            2'd2: begin
                mul.a = qx;
                mul.b = fp_pkg::add_mod(ta, tb, PRIME);
            end
            default: begin
                mul.a = qz;
                mul.b = fp_pkg::sub_mod(ta, tb, PRIME);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= isog_pkg::A_WAIT;
            pts.ack_eval <= 1'b0;
            mul.req <= 1'b0;
            done <= 1'b0;
            step <= '0;
            qx <= fp_pkg::fp_t'(1);
            qz <= fp_pkg::fp_t'(1);
        end else begin
            case (state)
                isog_pkg::A_WAIT: begin
                    if (pts.req) begin
                        mx <= pts.x;
                        mz <= pts.z;
                        last_q <= pts.last;
                        pts.ack_eval <= 1'b1;
                        state <= isog_pkg::A_HOLD;
                    end
                end
                isog_pkg::A_HOLD: begin
                    if (!pts.req) begin
                        pts.ack_eval <= 1'b0;
                        step <= '0;
                        state <= isog_pkg::A_CALC;
                    end
                end
                isog_pkg::A_CALC: begin
                    if (mul.req && mul.ack) begin
                        mul.req <= 1'b0;
                        step <= step + 2'd1;
                        case (step)
                            2'd0: ta <= mul.prod;
                            2'd1: tb <= mul.prod;
                            2'd2: qx <= mul.prod;
                            default: qz <= mul.prod;
                        endcase
                        if (step == 2'd3) begin
                            done <= last_q;
                            state <= last_q ? isog_pkg::A_DONE : isog_pkg::A_WAIT;
                        end
                    end else if (!mul.req && !mul.ack) begin
                        mul.req <= 1'b1;
                    end
                end
                default: begin
                    // rearm for the next job
                    if (clear) begin
                        done <= 1'b0;
                        qx <= fp_pkg::fp_t'(1);
                        qz <= fp_pkg::fp_t'(1);
                        state <= isog_pkg::A_WAIT;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/kernel_multiples.sv ====
`timescale 1ns/1ns
`default_nettype none

module kernel_multiples #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P,
    parameter isog_pkg::deg_t MAX_L = isog_pkg::DEFAULT_MAX_L
) (
    input wire clk,
    input wire rst,
    input wire start,
    input wire fp_pkg::fp_t kx,
    input wire fp_pkg::fp_t kz,
    input wire fp_pkg::fp_t a24,
    input wire isog_pkg::deg_t l,
    kernel_point_if.source pts,
    fp_mul_if.client mul
);

    // counter only has to reach (MAX_L-1)/2
    localparam int IW = $clog2(int'(MAX_L));

    isog_pkg::kern_state_e state;
    logic [IW-1:0] i;
    logic [2:0] step;
    logic [1:0] cur;
    logic [1:0] prv;
    logic [1:0] nxt;
    logic dbl;
    fp_pkg::fp_t mx [3];
    fp_pkg::fp_t mz [3];
    fp_pkg::fp_t t0;
    fp_pkg::fp_t t1;
    fp_pkg::fp_t t2;
    fp_pkg::fp_t sum_p;
    fp_pkg::fp_t dif_p;
    fp_pkg::fp_t sum_k;
    fp_pkg::fp_t dif_k;
    fp_pkg::fp_t t01_sum;
    fp_pkg::fp_t t01_dif;

    // M_i lives in slot i mod 3
    assign nxt = (cur == 2'd2) ? 2'd0 : cur + 2'd1;
    assign prv = (cur == 2'd0) ? 2'd2 : cur - 2'd1;
    assign dbl = (i == IW'(1));

    assign sum_p = fp_pkg::add_mod(mx[cur], mz[cur], PRIME);
    assign dif_p = fp_pkg::sub_mod(mx[cur], mz[cur], PRIME);
    assign sum_k = fp_pkg::add_mod(kx, kz, PRIME);
    assign dif_k = fp_pkg::sub_mod(kx, kz, PRIME);
    assign t01_sum = fp_pkg::add_mod(t0, t1, PRIME);
    assign t01_dif = fp_pkg::sub_mod(t0, t1, PRIME);

    assign pts.x = mx[cur];
    assign pts.z = mz[cur];
    assign pts.last = (i == IW'(l >> 1));

    // doubling takes 5 products, differential addition 6
    always_comb begin
        case (step)
            3'd0: begin
                mul.a = dbl ? sum_p : dif_p;
                mul.b = dbl ? sum_p : sum_k;
            end
            3'd1: begin
                mul.a = dbl ? dif_p : sum_p;
                mul.b = dbl ? dif_p : dif_k;
            end
            3'd2: begin
                mul.a = dbl ? t0 : t01_sum;
                mul.b = dbl ? t1 : t01_sum;
            end
            3'd3: begin
                mul.a = dbl ? a24 : mz[prv];
                mul.b = dbl ? t01_dif : t2;
            end
            3'd4: begin
                mul.a = t01_dif;
                mul.b = dbl ? fp_pkg::add_mod(t1, t2, PRIME) : t01_dif;
            end
            default: begin
                mul.a = mx[prv];
                mul.b = t2;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= isog_pkg::K_IDLE;
            pts.req <= 1'b0;
            mul.req <= 1'b0;
            i <= '0;
            step <= '0;
            cur <= '0;
        end else begin
            case (state)
                isog_pkg::K_IDLE: begin
                    if (start) begin
                        mx[1] <= kx;
                        mz[1] <= kz;
                        cur <= 2'd1;
                        i <= IW'(1);
                        pts.req <= 1'b1;
                        state <= isog_pkg::K_EMIT;
                    end
                end
                isog_pkg::K_EMIT: begin
                    if (pts.ack_eval && pts.ack_curve) begin
                        pts.req <= 1'b0;
                        state <= isog_pkg::K_DROP;
                    end
                end
                isog_pkg::K_DROP: begin
                    if (!pts.ack_eval && !pts.ack_curve) begin
                        step <= '0;
                        state <= pts.last ? isog_pkg::K_DONE : isog_pkg::K_CALC;
                    end
                end
                isog_pkg::K_CALC: begin
                    if (mul.req && mul.ack) begin
                        mul.req <= 1'b0;
                        step <= step + 3'd1;
                        case (step)
                            3'd0: t0 <= mul.prod;
                            3'd1: t1 <= mul.prod;
                            3'd2: if (dbl) mx[nxt] <= mul.prod; else t2 <= mul.prod;
                            3'd3: if (dbl) t2 <= mul.prod; else mx[nxt] <= mul.prod;
                            3'd4: if (dbl) mz[nxt] <= mul.prod; else t2 <= mul.prod;
                            default: mz[nxt] <= mul.prod;
                        endcase
                        if (step == (dbl ? 3'd4 : 3'd5)) begin
                            cur <= nxt;
                            i <= i + 1'b1;
                            pts.req <= 1'b1;
                            state <= isog_pkg::K_EMIT;
                        end
                    end else if (!mul.req && !mul.ack) begin
                        mul.req <= 1'b1;
                    end
                end
                isog_pkg::K_DONE: begin
                    if (!start) begin
                        state <= isog_pkg::K_IDLE;
                    end
                end
                default: state <= isog_pkg::K_IDLE;
            endcase
        end
    end

    // a multiple stays on offer until both accumulators hold it
    assert property (@(posedge clk) disable iff (rst)
        pts.req && !(pts.ack_eval && pts.ack_curve) |=> pts.req);

    // odd degree of at least 3 that the counter can reach
    assert property (@(posedge clk) disable iff (rst)
        state == isog_pkg::K_IDLE && start |-> l[0] && l >= 7'd3 && l <= MAX_L);

endmodule

`default_nettype wire

// ==== src/fp_mul.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_mul #(
    parameter fp_pkg::fp_t PRIME = fp_pkg::DEFAULT_P
) (
    input wire clk,
    input wire rst,
    fp_mul_if.server mul
);

    localparam int CW = $clog2(fp_pkg::FP_W + 1);

    logic busy;
    logic [CW-1:0] cnt;
    fp_pkg::fp_t b_sh;
    fp_pkg::fp_t dbl_v;
    fp_pkg::fp_t step_v;

    // double the partial product, then add a if the current bit of b is set
    always_comb begin
        dbl_v = fp_pkg::add_mod(mul.prod, mul.prod, PRIME);
        if (b_sh[fp_pkg::FP_W-1]) begin
            step_v = fp_pkg::add_mod(dbl_v, mul.a, PRIME);
        end else begin
            step_v = dbl_v;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
            mul.ack <= 1'b0;
        end else if (busy) begin
            if (cnt == CW'(fp_pkg::FP_W)) begin
                busy <= 1'b0;
                mul.ack <= 1'b1;
            end else begin
                mul.prod <= step_v;
                b_sh <= b_sh << 1;
                cnt <= cnt + 1'b1;
            end
        end else if (mul.ack) begin
            // product held until the client lets go
            if (!mul.req) begin
                mul.ack <= 1'b0;
            end
        end else if (mul.req) begin
            busy <= 1'b1;
            cnt <= '0;
            b_sh <= mul.b;
            mul.prod <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/isog_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// one multiplier call, four-phase req/ack
interface fp_mul_if;
    fp_pkg::fp_t a;
    fp_pkg::fp_t b;
    fp_pkg::fp_t prod;
    logic req;
    logic ack;
    modport client (output a, b, req, input prod, ack);
    modport server (input a, b, req, output prod, ack);
endinterface

// kernel multiples, each sink acknowledges on its own
interface kernel_point_if;
    fp_pkg::fp_t x;
    fp_pkg::fp_t z;
    logic last;
    logic req;
    logic ack_eval;
    logic ack_curve;
    modport source (output x, z, last, req, input ack_eval, ack_curve);
    modport eval_sink (input x, z, last, req, output ack_eval);
    modport curve_sink (input x, z, last, req, output ack_curve);
endinterface

`default_nettype wire

// ==== src/isog_pkg.sv ====
`default_nettype none

package isog_pkg;

    typedef logic [6:0] deg_t;

    // largest degree the multiple counter is sized for
    localparam deg_t DEFAULT_MAX_L = 7'd31;

    typedef enum logic [2:0] {
        K_IDLE,
        K_EMIT,
        K_DROP,
        K_CALC,
        K_DONE
    } kern_state_e;

    typedef enum logic [1:0] {
        A_WAIT,
        A_HOLD,
        A_CALC,
        A_DONE
    } acc_state_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_CALC,
        F_ACK
    } fin_state_e;

endpackage

`default_nettype wire

// ==== src/fp_pkg.sv ====
`default_nettype none

package fp_pkg;

    localparam int FP_W = 16;

    typedef logic [FP_W-1:0] fp_t;

    // largest 16-bit prime
    localparam fp_t DEFAULT_P = 16'd65521;

    // both operands already below p
    function automatic fp_t add_mod(input fp_t a, input fp_t b, input fp_t p);
        logic [FP_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, p}) begin
            s = s - {1'b0, p};
        end
        return s[FP_W-1:0];
    endfunction

    function automatic fp_t sub_mod(input fp_t a, input fp_t b, input fp_t p);
        fp_t d;
        d = a - b;
        if (a < b) begin
            d = d + p;
        end
        return d;
    endfunction

endpackage

`default_nettype wire
